/* rtl/rvv_backend_macros.svh */
// ########################################
// decode widths, uop index width and
// queue depths of the vector front end
// ########################################

`ifndef RVV_BACKEND_MACROS_SVH
`define RVV_BACKEND_MACROS_SVH

// decode units and push lanes
`define NUM_DE_INST       2
`define NUM_DE_UOP        4
`define NUM_DE_UOP_WIDTH  3

// uop index inside one command
`define UOP_INDEX_WIDTH   3

// queue depths
`define CQ_DEPTH          8
`define UQ_DEPTH          16

`endif

/* rtl/rvv_cmd_pkg.sv */
// ########################################
// command types of the vector front end
// ########################################

package rvv_cmd_pkg;

  typedef logic [7:0] opcode_t;

  typedef logic [4:0] vreg_t;

  // 0..3 select 1, 2, 4 or 8 uops
  typedef logic [1:0] lmul_t;

  typedef struct packed {
    opcode_t opcode;
    vreg_t   vd;
    lmul_t   lmul;
  } cmd_t;

endpackage

/* rtl/rvv_uop_pkg.sv */
// ########################################
// uop types and uop queue occupancy count
// ########################################

`include "rvv_backend_macros.svh"

package rvv_uop_pkg;

  typedef logic [`UOP_INDEX_WIDTH-1:0] uop_index_t;

  // one entry of the uop queue
  typedef struct packed {
    rvv_cmd_pkg::opcode_t opcode;
    rvv_cmd_pkg::vreg_t   vd;
    uop_index_t           uop_index;
    logic                 last_uop_valid;
  } uop_t;

  // counts 0..UQ_DEPTH inclusive
  typedef logic [$clog2(`UQ_DEPTH + 1)-1:0] uq_count_t;

endpackage

/* rtl/rvv_uq_push_if.sv */
// ########################################
// four-lane push into the uop queue
// ########################################

`include "rvv_backend_macros.svh"

interface rvv_uq_push_if;
  import rvv_uop_pkg::*;

  logic [`NUM_DE_UOP-1:0] push;
  uop_t [`NUM_DE_UOP-1:0] data;
  logic                   full;
  // bit k set when exactly k entries are free
  logic [`NUM_DE_UOP-1:1] almost_full;

  modport ctrl  (output push, output data, input full, input almost_full);
  modport queue (input push, input data, output full, output almost_full);

endinterface

/* rtl/rvv_cmd_queue.sv */
// ########################################
// command FIFO, one write port and two
// read ports, pops 0, 1 or 2 per cycle
// ########################################

`include "rvv_backend_macros.svh"

module rvv_cmd_queue (
  input  logic                                 clk,
  input  logic                                 reset,
  input  logic                                 wr_valid,
  input  rvv_cmd_pkg::cmd_t                    wr_data,
  output logic                                 wr_ready,
  output logic [`NUM_DE_INST-1:0]              pkg_valid,
  output rvv_cmd_pkg::cmd_t [`NUM_DE_INST-1:0] cmd,
  input  logic [`NUM_DE_INST-1:0]              pop
);
  import rvv_cmd_pkg::*;

  localparam int PTR_W = $clog2(`CQ_DEPTH);
  localparam int CNT_W = $clog2(`CQ_DEPTH + 1);

  cmd_t             mem [`CQ_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic [CNT_W-1:0] pop_num;
  logic             wr_en;

  assign wr_ready = (count != CNT_W'(`CQ_DEPTH));
  assign wr_en    = wr_valid && wr_ready;

  // pops are contiguous from the head
  always_comb begin
    pop_num = '0;
    for (int i = 0; i < `NUM_DE_INST; i++) begin
      pop_num = pop_num + CNT_W'(pop[i]);
    end
  end

  // head and head+1, pointer wraps at the depth
  for (genvar i = 0; i < `NUM_DE_INST; i++) begin : g_rd
    assign pkg_valid[i] = (count > CNT_W'(i));
    assign cmd[i]       = mem[rd_ptr + PTR_W'(i)];
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      rd_ptr <= rd_ptr + PTR_W'(pop_num);
      count  <= count + CNT_W'(wr_en) - pop_num;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= wr_data;
    end
  end

  // the controller pops only commands it can see
  a_pop_valid: assert property (@(posedge clk) disable iff (reset)
    (pop & ~pkg_valid) == '0)
    else $error("command pop of an empty entry");

  // the read pointer advance assumes the head goes first
  a_pop_order: assert property (@(posedge clk) disable iff (reset)
    pop[1] |-> pop[0])
    else $error("second command popped before the head");

  a_no_overflow: assert property (@(posedge clk) disable iff (reset)
    count <= CNT_W'(`CQ_DEPTH))
    else $error("command queue written while full");

endmodule

/* rtl/rvv_decode_unit.sv */
// ########################################
// expands one command into up to four
// uops from a given uop index
// ########################################

`include "rvv_backend_macros.svh"

module rvv_decode_unit (
  input  logic                                cmd_valid,
  input  rvv_cmd_pkg::cmd_t                   cmd,
  input  rvv_uop_pkg::uop_index_t             start_index,
  output logic [`NUM_DE_UOP-1:0]              uop_valid,
  output rvv_uop_pkg::uop_t [`NUM_DE_UOP-1:0] uops
);
  import rvv_cmd_pkg::*;
  import rvv_uop_pkg::*;

  // one bit wider than the index so start + slot never wraps
  localparam int POS_W = `UOP_INDEX_WIDTH + 1;

  logic [POS_W-1:0] uop_num;
  logic [POS_W-1:0] slot_pos [`NUM_DE_UOP];
  vreg_t            slot_vd  [`NUM_DE_UOP];

  // lmul code n gives 2**n uops
  assign uop_num = POS_W'(1) << cmd.lmul;

  for (genvar k = 0; k < `NUM_DE_UOP; k++) begin : g_slot
    assign slot_pos[k] = {1'b0, start_index} + POS_W'(k);

    // register group wraps at v31
    assign slot_vd[k] = cmd.vd + vreg_t'(slot_pos[k]);

    assign uop_valid[k] = cmd_valid && (slot_pos[k] < uop_num);

    assign uops[k].opcode    = cmd.opcode;
    assign uops[k].vd        = slot_vd[k];
    assign uops[k].uop_index = uop_index_t'(slot_pos[k]);

    // only a valid slot can carry the final uop
    assign uops[k].last_uop_valid = uop_valid[k] && (slot_pos[k] == uop_num - 1'b1);
  end

endmodule

/* rtl/rvv_decode_ctrl.sv */
// ########################################
// packs two decode units into four push
// lanes, drives pops and remaining index
// ########################################

`include "rvv_backend_macros.svh"

module rvv_decode_ctrl (
  input  logic                                                  clk,
  input  logic                                                  reset,
  input  logic [`NUM_DE_INST-1:0]                               pkg_valid,
  input  logic [`NUM_DE_INST-1:0][`NUM_DE_UOP-1:0]              uop_valid_de2uq,
  input  rvv_uop_pkg::uop_t [`NUM_DE_INST-1:0][`NUM_DE_UOP-1:0] uop_de2uq,
  output rvv_uop_pkg::uop_index_t                               uop_index_remain,
  output logic [`NUM_DE_INST-1:0]                               pop,
  rvv_uq_push_if.ctrl                                           uq
);
  import rvv_uop_pkg::*;

  // valid uops of unit 0, and lanes left over for unit 1
  logic [`NUM_DE_UOP_WIDTH-1:0] quantity;
  logic [`NUM_DE_UOP_WIDTH-1:0] taken1;
  logic [`NUM_DE_INST-1:0]      last_uop_unit;
  logic [`NUM_DE_UOP-1:0]       lane_valid;
  uop_t [`NUM_DE_UOP-1:0]       lane_data;
  logic                         fifo_ready;

  // at least four free entries in the uop queue
  assign fifo_ready = !(uq.full || (|uq.almost_full));

  // unit 0 slots are contiguous so a plain count is enough
  always_comb begin
    quantity = '0;
    for (int s = 0; s < `NUM_DE_UOP; s++) begin
      quantity = quantity + `NUM_DE_UOP_WIDTH'(uop_valid_de2uq[0][s]);
    end
  end

  assign taken1 = `NUM_DE_UOP_WIDTH'(`NUM_DE_UOP) - quantity;

  // unit 0 first, unit 1 fills the lanes behind it
  always_comb begin
    for (int j = 0; j < `NUM_DE_UOP; j++) begin
      if (j < quantity) begin
        lane_valid[j] = uop_valid_de2uq[0][j];
        lane_data[j]  = uop_de2uq[0][j];
      end else begin
        lane_valid[j] = uop_valid_de2uq[1][j - quantity];
        lane_data[j]  = uop_de2uq[1][j - quantity];
      end
    end
  end

  // last uop of each unit within the lanes it got
  always_comb begin
    last_uop_unit = '0;
    for (int s = 0; s < `NUM_DE_UOP; s++) begin
      if (uop_de2uq[0][s].last_uop_valid) begin
        last_uop_unit[0] = 1'b1;
      end
      if ((s < taken1) && uop_de2uq[1][s].last_uop_valid) begin
        last_uop_unit[1] = 1'b1;
      end
    end
  end

  assign pop[0] = fifo_ready && pkg_valid[0] && last_uop_unit[0];
  assign pop[1] = pop[0] && pkg_valid[1] && last_uop_unit[1];

  assign uq.push = fifo_ready ? lane_valid : '0;
  assign uq.data = lane_data;

  always_ff @(posedge clk) begin
    if (reset) begin
      uop_index_remain <= '0;
    end else if (pop[0]) begin
      // second command becomes head, resume where its lanes stopped
      if (pkg_valid[1] && !pop[1]) begin
        uop_index_remain <= uop_index_t'(taken1);
      end else begin
        uop_index_remain <= '0;
      end
    end else if (fifo_ready && pkg_valid[0]) begin
      // head still open after a full group of lanes
      uop_index_remain <= uop_index_remain + uop_index_t'(quantity);
    end
  end

  // lanes filled from lane 0 with no gaps
  a_push_contig: assert property (@(posedge clk) disable iff (reset)
    ((uq.push + 1'b1) & uq.push) == '0)
    else $error("push lanes not contiguous");

endmodule

/* rtl/rvv_uop_queue.sv */
// ########################################
// uop FIFO, four write lanes, one read
// port, full and almost-full flags
// ########################################

`include "rvv_backend_macros.svh"

module rvv_uop_queue (
  input  logic              clk,
  input  logic              reset,
  rvv_uq_push_if.queue      uq,
  output logic              rd_valid,
  output rvv_uop_pkg::uop_t rd_data,
  input  logic              rd_ready
);
  import rvv_uop_pkg::*;

  localparam int PTR_W = $clog2(`UQ_DEPTH);

  uop_t             mem [`UQ_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  uq_count_t        count;
  uq_count_t        free;
  uq_count_t        push_num;
  logic             rd_en;

  always_comb begin
    push_num = '0;
    for (int k = 0; k < `NUM_DE_UOP; k++) begin
      push_num = push_num + uq_count_t'(uq.push[k]);
    end
  end

  assign free    = uq_count_t'(`UQ_DEPTH) - count;
  assign uq.full = (count == uq_count_t'(`UQ_DEPTH));

  for (genvar k = 1; k < `NUM_DE_UOP; k++) begin : g_afull
    assign uq.almost_full[k] = (free == uq_count_t'(k));
  end

  assign rd_valid = (count != '0);
  assign rd_data  = mem[rd_ptr];
  assign rd_en    = rd_valid && rd_ready;

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      wr_ptr <= wr_ptr + PTR_W'(push_num);
      if (rd_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      count <= count + push_num - uq_count_t'(rd_en);
    end
  end

  // lane k lands k entries after the write pointer
  always_ff @(posedge clk) begin
    for (int k = 0; k < `NUM_DE_UOP; k++) begin
      if (uq.push[k]) begin
        mem[wr_ptr + PTR_W'(k)] <= uq.data[k];
      end
    end
  end

  // a push needs room for a whole group of lanes
  a_push_room: assert property (@(posedge clk) disable iff (reset)
    |uq.push |-> free >= uq_count_t'(`NUM_DE_UOP))
    else $error("uop push without four free entries");

  a_no_overflow: assert property (@(posedge clk) disable iff (reset)
    (int'(count) + int'(push_num)) <= `UQ_DEPTH)
    else $error("uop queue overflow");

endmodule

/* rtl/rvv_decode_top.sv */
// ########################################
// command queue, two decoders, controller
// and uop queue of the decode stage
// ########################################

`include "rvv_backend_macros.svh"

module rvv_decode_top (
  input  logic              clk,
  input  logic              reset,
  input  logic              cmd_valid,
  input  rvv_cmd_pkg::cmd_t cmd_data,
  output logic              cmd_ready,
  output logic              uop_valid,
  output rvv_uop_pkg::uop_t uop_data,
  input  logic              uop_ready
);
  import rvv_cmd_pkg::*;
  import rvv_uop_pkg::*;

  logic [`NUM_DE_INST-1:0]                  pkg_valid;
  cmd_t [`NUM_DE_INST-1:0]                  cmd_cq2de;
  logic [`NUM_DE_INST-1:0]                  pop;
  logic [`NUM_DE_INST-1:0][`NUM_DE_UOP-1:0] uop_valid_de2uq;
  uop_t [`NUM_DE_INST-1:0][`NUM_DE_UOP-1:0] uop_de2uq;
  uop_index_t                               uop_index_remain;

  rvv_uq_push_if uq_if ();

  rvv_cmd_queue u_cmd_queue (
    .clk       (clk),
    .reset     (reset),
    .wr_valid  (cmd_valid),
    .wr_data   (cmd_data),
    .wr_ready  (cmd_ready),
    .pkg_valid (pkg_valid),
    .cmd       (cmd_cq2de),
    .pop       (pop)
  );

  // head resumes at the remaining index
  rvv_decode_unit u_decode_unit0 (
    .cmd_valid   (pkg_valid[0]),
    .cmd         (cmd_cq2de[0]),
    .start_index (uop_index_remain),
    .uop_valid   (uop_valid_de2uq[0]),
    .uops        (uop_de2uq[0])
  );

  rvv_decode_unit u_decode_unit1 (
    .cmd_valid   (pkg_valid[1]),
    .cmd         (cmd_cq2de[1]),
    .start_index (uop_index_t'(0)),
    .uop_valid   (uop_valid_de2uq[1]),
    .uops        (uop_de2uq[1])
  );

  rvv_decode_ctrl u_decode_ctrl (
    .clk              (clk),
    .reset            (reset),
    .pkg_valid        (pkg_valid),
    .uop_valid_de2uq  (uop_valid_de2uq),
    .uop_de2uq        (uop_de2uq),
    .uop_index_remain (uop_index_remain),
    .pop              (pop),
    .uq               (uq_if.ctrl)
  );

  rvv_uop_queue u_uop_queue (
    .clk      (clk),
    .reset    (reset),
    .uq       (uq_if.queue),
    .rd_valid (uop_valid),
    .rd_data  (uop_data),
    .rd_ready (uop_ready)
  );

endmodule

/* tests/tb_rvv_decode.sv */
// ########################################
// testbench of the decode stage, reference
// expansion, stimulus and uop scoreboard
// ########################################

module tb_rvv_decode;
  timeunit 1ns;
  timeprecision 100ps;
  import rvv_cmd_pkg::*;
  import rvv_uop_pkg::*;

  localparam logic [31:0] SEED       = 32'd27713;
  localparam int          WAIT_LIMIT = 2000;

  logic clk;
  logic reset;
  logic cmd_valid;
  cmd_t cmd_data;
  logic cmd_ready;
  logic uop_valid;
  uop_t uop_data;
  logic uop_ready;

  // expected uops in arrival order
  uop_t        sb [$];
  logic [31:0] cmd_rng;
  logic [31:0] rdy_rng;
  // 0 always ready, 1 random, 2 held low
  int          ready_mode;

  rvv_decode_top UUT (
    .clk       (clk),
    .reset     (reset),
    .cmd_valid (cmd_valid),
    .cmd_data  (cmd_data),
    .cmd_ready (cmd_ready),
    .uop_valid (uop_valid),
    .uop_data  (uop_data),
    .uop_ready (uop_ready)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x;
    y = y ^ (y << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // one uop per register of the group, destination wraps at v31
  function automatic void expand_cmd(input cmd_t c);
    int   n;
    uop_t u;
    n = 1 << c.lmul;
    for (int i = 0; i < n; i++) begin
      u.opcode         = c.opcode;
      u.vd             = vreg_t'(c.vd + i);
      u.uop_index      = uop_index_t'(i);
      u.last_uop_valid = (i == n - 1);
      sb.push_back(u);
    end
  endfunction

  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display(">>> FAIL");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      stop_with_failure($sformatf("Error: %s is 0x%0h, expected 0x%0h",
                                  name, actual, expected));
    end
  endtask

  // cmd_ready comes from a register, so it is stable 1 ns after the edge
  task automatic send_cmd(input cmd_t c);
    int tries;
    tries     = 0;
    cmd_data  = c;
    cmd_valid = 1'b1;
    while (!cmd_ready && tries < WAIT_LIMIT) begin
      @(posedge clk);
      #1;
      tries++;
    end
    if (!cmd_ready) begin
      stop_with_failure("cmd_ready stayed low, the command could not be sent");
    end else begin
      expand_cmd(c);
      @(posedge clk);
      #1;
      cmd_valid = 1'b0;
    end
  endtask

  // negative lmul_sel picks a random group size
  task automatic send_random(input int lmul_sel);
    cmd_t c;
    cmd_rng  = xorshift(cmd_rng);
    c.opcode = cmd_rng[7:0];
    c.vd     = cmd_rng[12:8];
    c.lmul   = (lmul_sel < 0) ? cmd_rng[14:13] : lmul_t'(lmul_sel);
    send_cmd(c);
  endtask

  task automatic wait_for_drain();
    int tries;
    tries = 0;
    while (sb.size() != 0 && tries < WAIT_LIMIT) begin
      @(posedge clk);
      #1;
      tries++;
    end
    if (sb.size() != 0) begin
      stop_with_failure($sformatf("timeout with %0d uops still expected", sb.size()));
    end else begin
      check_value("uop_valid", uop_valid, 0);
    end
  endtask

  always @(posedge clk) begin
    #1;
    case (ready_mode)
      0: uop_ready = 1'b1;
      1: begin
        rdy_rng   = xorshift(rdy_rng);
        uop_ready = rdy_rng[3];
      end
      default: uop_ready = 1'b0;
    endcase
  end

  // mid-cycle sample, the handshake happens at the next rising edge
  always @(negedge clk) begin : compare_uops
    uop_t expected;
    if (!reset && uop_valid && uop_ready) begin
      if (sb.size() == 0) begin
        stop_with_failure("a uop arrived while none was expected");
      end else begin
        expected = sb.pop_front();
        check_value("uop_data.opcode", uop_data.opcode, expected.opcode);
        check_value("uop_data.vd", uop_data.vd, expected.vd);
        check_value("uop_data.uop_index", uop_data.uop_index, expected.uop_index);
        check_value("uop_data.last_uop_valid", uop_data.last_uop_valid,
                    expected.last_uop_valid);
      end
    end
  end

  initial begin
    int tries;
    reset      = 1'b1;
    cmd_valid  = 1'b0;
    cmd_data   = '0;
    uop_ready  = 1'b0;
    ready_mode = 0;
    cmd_rng    = SEED;
    rdy_rng    = SEED ^ 32'h9e37_79b9;
    repeat (16) @(posedge clk);
    #1;
    reset = 1'b0;

    check_value("uop_valid", uop_valid, 0);
    check_value("cmd_ready", cmd_ready, 1);

    // single uop commands
    for (int i = 0; i < 12; i++) begin
      send_random(0);
    end
    wait_for_drain();

    // eight uops each, split over two cycles
    for (int i = 0; i < 6; i++) begin
      send_random(3);
    end
    wait_for_drain();

    // mixed sizes, two commands can share a cycle
    for (int i = 0; i < 40; i++) begin
      send_random(-1);
    end
    wait_for_drain();

    ready_mode = 1;
    for (int i = 0; i < 60; i++) begin
      send_random(-1);
    end
    wait_for_drain();

    // stall the consumer until the command queue fills
    ready_mode = 2;
    tries      = 0;
    while (cmd_ready && tries < 200) begin
      send_random(-1);
      tries++;
    end
    if (cmd_ready) begin
      stop_with_failure("cmd_ready did not fall with uop_ready held low");
    end else begin
      check_value("uop_valid", uop_valid, 1);
      ready_mode = 0;
      tries      = 0;
      while (sb.size() != 0 && tries < WAIT_LIMIT) begin
        @(posedge clk);
        #1;
        tries++;
      end
      if (sb.size() == 0) begin
        // nothing left behind the last expected uop
        check_value("uop_valid", uop_valid, 0);
        $display(">>> PASS");
        $finish;
      end else begin
        stop_with_failure("timeout while draining after back-pressure");
      end
    end
  end

endmodule

/* all.f */
+incdir+rtl
rtl/rvv_cmd_pkg.sv
rtl/rvv_uop_pkg.sv
rtl/rvv_uq_push_if.sv
rtl/rvv_cmd_queue.sv
rtl/rvv_decode_unit.sv
rtl/rvv_decode_ctrl.sv
rtl/rvv_uop_queue.sv
rtl/rvv_decode_top.sv
tests/tb_rvv_decode.sv
